/* readout_geom_pkg.sv */
/*
 * Pixel readout geometry
 * Default array size, address widths and downstream buffer depth
 * shared by the readout RTL and its testbench
 */

package readout_geom_pkg;

    // ----------------------------
    // Pixel array
    // ----------------------------
    localparam int n_rows_dflt     = 8;   // Pixel rows
    localparam int n_cols_dflt     = 8;   // Pixel columns
    localparam int row_addr_w_dflt = 3;   // Encoded row index width
    localparam int col_addr_w_dflt = 3;   // Encoded column index width

    // ----------------------------
    // Flow control
    // ----------------------------
    localparam int n_credits_dflt  = 4;   // Downstream buffer depth in events

endpackage

/* readout_reg_pkg.sv */
/*
 * Readout configuration register map
 * Addresses, field positions and widths of the CTRL, ROW_SKIP
 * and FRAMES registers
 */

package readout_reg_pkg;

    localparam int reg_addr_w = 2;                       // Register address width
    localparam int reg_data_w = 16;                      // Register data width

    // ----------------------------
    // Addresses
    // ----------------------------
    localparam logic [reg_addr_w-1:0] reg_ctrl_addr     = 2'd0;  // CTRL
    localparam logic [reg_addr_w-1:0] reg_row_skip_addr = 2'd1;  // ROW_SKIP, one bit per row
    localparam logic [reg_addr_w-1:0] reg_frames_addr   = 2'd2;  // FRAMES, read only

    // ----------------------------
    // CTRL fields
    // ----------------------------
    localparam int ctrl_en_bit = 0;                      // Readout enable

endpackage

/* arb_if.sv */
/*
 * Arbiter bus
 * Step and refresh controls, request vector and the registered
 * grant, index and group release of one round-robin arbiter
 */

`timescale 1ns/100ps

interface arb_if import readout_geom_pkg::*;
#(
    parameter int n_lines = n_rows_dflt,   // Request lines
    parameter int addr_w  = row_addr_w_dflt // Encoded index width
);

    logic               enable;            // Advance one step
    logic               refresh;           // Reload mask, clear grant
    logic [n_lines-1:0] req;               // Request vector
    logic [n_lines-1:0] gnt;               // Registered one-hot grant
    logic [addr_w-1:0]  addr;              // Index of gnt
    logic               grp_release;       // No masked requests left

    modport ctrl
    (
        output enable, refresh, req,
        input  gnt, addr, grp_release
    );

    modport arb
    (
        input  enable, refresh, req,
        output gnt, addr, grp_release
    );

endinterface

/* priority_arb.sv */
/*
 * Fixed priority grant finder
 * Grants the lowest index set request, no grant without requests
 */

`timescale 1ns/100ps

module priority_arb import readout_geom_pkg::*;
#(
    parameter int n_lines = n_rows_dflt      // Request lines
)
(
    input  logic [n_lines-1:0] req_i,        // Requests
    output logic [n_lines-1:0] gnt_o         // One-hot grant
);

    logic [n_lines-1:0] req_neg;             // Two's complement of req_i

    assign req_neg = ~req_i + n_lines'(1);   // Borrow stops at lowest set bit
    assign gnt_o   = req_i & req_neg;        // Isolate lowest set bit

endmodule

/* row_arbiter.sv */
/*
 * Round-robin arbiter
 * Masks off every line at or below the last grant so the scan moves
 * upward, wraps to the raw requests once the mask runs empty, and
 * registers the one-hot grant together with its encoded index
 */

`timescale 1ns/100ps

module row_arbiter import readout_geom_pkg::*;
#(
    parameter int n_lines = n_rows_dflt,       // Request lines
    parameter int addr_w  = row_addr_w_dflt    // Encoded index width
)
(
    input  logic  clk_i,                       // System clock
    input  logic  reset_i,                     // Async reset, active high
    arb_if.arb    arb                          // Arbiter bus
);

    // ----------------------------
    // Mask and grant select
    // ----------------------------
    logic [n_lines-1:0] mask_q;                // Lines still eligible this round
    logic [n_lines-1:0] mask_nxt;              // Lines above the new grant
    logic [n_lines-1:0] mask_req;              // Eligible requests
    logic [n_lines-1:0] mask_gnt;              // Lowest eligible request
    logic [n_lines-1:0] raw_gnt;               // Lowest request overall
    logic [n_lines-1:0] gnt_nxt;               // Grant taken on enable
    logic [n_lines-1:0] gnt_q;                 // Registered grant

    assign mask_req        = arb.req & mask_q;
    assign gnt_nxt         = (|mask_req) ? mask_gnt : raw_gnt;  // Wrap when mask is empty
    assign mask_nxt        = ~((gnt_nxt << 1) - n_lines'(1));   // Ones strictly above grant
    assign arb.grp_release = ~(|mask_req);

    priority_arb #(.n_lines(n_lines)) i_masked_arb
    (
        .req_i (mask_req),
        .gnt_o (mask_gnt)
    );

    priority_arb #(.n_lines(n_lines)) i_raw_arb
    (
        .req_i (arb.req),
        .gnt_o (raw_gnt)
    );

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q <= '1;                      // All lines eligible
            gnt_q  <= '0;
        end
        else if (arb.enable)
        begin
            mask_q <= mask_nxt;
            gnt_q  <= gnt_nxt;
        end
        else if (arb.refresh)
        begin
            mask_q <= '1;                      // New round from line 0
            gnt_q  <= '0;
        end
    end

    // ----------------------------
    // Index encode
    // ----------------------------
    always_comb
    begin
        arb.addr = '0;
        for (int i = 0; i < n_lines; i++)
        begin
            if (gnt_q[i])
            begin
                arb.addr = addr_w'(i);
            end
        end
    end

    assign arb.gnt = gnt_q;

    // At most one line owns the bus at any time
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_q));

endmodule

/* readout_regs.sv */
/*
 * Readout configuration registers
 * CTRL enable and ROW_SKIP mask written from the config port,
 * FRAMES counts completed frames, reads are combinational
 */

`timescale 1ns/100ps

module readout_regs import readout_geom_pkg::*, readout_reg_pkg::*;
#(
    parameter int n_rows = n_rows_dflt                  // Pixel rows
)
(
    input  logic                  clk_i,                // System clock
    input  logic                  reset_i,              // Async reset, active high
    input  logic                  cfg_we_i,             // Write strobe
    input  logic [reg_addr_w-1:0] cfg_addr_i,           // Register address
    input  logic [reg_data_w-1:0] cfg_wdata_i,          // Write data
    output logic [reg_data_w-1:0] cfg_rdata_o,          // Read data
    input  logic                  frame_done_i,         // Frame completed pulse
    output logic                  scan_en_o,            // Readout enable
    output logic [n_rows-1:0]     row_skip_o            // Rows excluded from scan
);

    logic                  scan_en_q;                   // CTRL enable bit
    logic [n_rows-1:0]     row_skip_q;                  // ROW_SKIP
    logic [reg_data_w-1:0] frames_q;                    // FRAMES, wraps

    // ----------------------------
    // Writes and frame counter
    // ----------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            scan_en_q  <= 1'b0;                         // Readout starts disabled
            row_skip_q <= '0;
            frames_q   <= '0;
        end
        else
        begin
            if (cfg_we_i && cfg_addr_i == reg_ctrl_addr)
                scan_en_q <= cfg_wdata_i[ctrl_en_bit];
            if (cfg_we_i && cfg_addr_i == reg_row_skip_addr)
                row_skip_q <= cfg_wdata_i[n_rows-1:0];
            if (frame_done_i)
                frames_q <= frames_q + 1'b1;
        end
    end

    // ----------------------------
    // Read mux
    // ----------------------------
    always_comb
    begin
        cfg_rdata_o = '0;                               // Unmapped reads as zero
        case (cfg_addr_i)
            reg_ctrl_addr:     cfg_rdata_o[ctrl_en_bit] = scan_en_q;
            reg_row_skip_addr: cfg_rdata_o = reg_data_w'(row_skip_q);
            reg_frames_addr:   cfg_rdata_o = frames_q;
            default:           cfg_rdata_o = '0;
        endcase
    end

    assign scan_en_o  = scan_en_q;
    assign row_skip_o = row_skip_q;

endmodule

/* readout_ctrl.sv */
/*
 * Readout controller
 * Captures a hit frame, steps the row arbiter over rows with hits
 * and the column arbiter over the hits of each granted row, and
 * emits one address event per hit against a credit counter
 */

`timescale 1ns/100ps

module readout_ctrl import readout_geom_pkg::*;
#(
    parameter int n_rows     = n_rows_dflt,          // Pixel rows
    parameter int n_cols     = n_cols_dflt,          // Pixel columns
    parameter int row_addr_w = row_addr_w_dflt,      // Row index width
    parameter int col_addr_w = col_addr_w_dflt,      // Column index width
    parameter int n_credits  = n_credits_dflt        // Downstream buffer depth
)
(
    input  logic                     clk_i,          // System clock
    input  logic                     reset_i,        // Async reset, active high
    input  logic [n_rows*n_cols-1:0] hit_i,          // Hit vector, row major
    input  logic                     scan_en_i,      // Readout enable
    input  logic [n_rows-1:0]        row_skip_i,     // Rows excluded from scan
    input  logic                     credit_i,       // One credit returned
    arb_if.ctrl                      row_arb,        // Row arbiter bus
    arb_if.ctrl                      col_arb,        // Column arbiter bus
    output logic                     evt_valid_o,    // Event present
    output logic [row_addr_w-1:0]    evt_row_o,      // Event row
    output logic [col_addr_w-1:0]    evt_col_o,      // Event column
    output logic                     frame_done_o    // Frame completed pulse
);

    localparam int cred_w = $clog2(n_credits + 1);

    // ----------------------------
    // FSM encoding
    // ----------------------------
    localparam logic [2:0] st_idle    = 3'd0;        // Wait for enable and hits
    localparam logic [2:0] st_capture = 3'd1;        // Frame held, first row step
    localparam logic [2:0] st_row     = 3'd2;        // Row granted, refresh columns
    localparam logic [2:0] st_col     = 3'd3;        // Column step when credit allows
    localparam logic [2:0] st_emit    = 3'd4;        // Event on the output
    localparam logic [2:0] st_done    = 3'd5;        // Frame end pulse

    logic [2:0]               state_q;
    logic [2:0]               state_nxt;
    logic [n_rows*n_cols-1:0] frame_q;               // Captured hit frame
    logic [n_rows-1:0]        row_any;               // Rows holding any hit
    logic [cred_w-1:0]        credit_q;              // Free downstream slots
    logic                     capture;               // Frame taken this edge
    logic                     has_credit;

    assign capture    = (state_q == st_idle) && scan_en_i && (|hit_i);
    assign has_credit = (credit_q != '0);

    always_ff @(posedge clk_i)
    begin
        if (capture)
            frame_q <= hit_i;
    end

    // ----------------------------
    // Request vectors
    // ----------------------------
    always_comb
    begin
        for (int r = 0; r < n_rows; r++)
            row_any[r] = |frame_q[r*n_cols +: n_cols];
    end

    assign row_arb.req = row_any & ~row_skip_i;                     // Skipped rows never request
    assign col_arb.req = frame_q[row_arb.addr * n_cols +: n_cols];  // Hits of granted row

    // ----------------------------
    // Arbiter steering
    // ----------------------------
    assign row_arb.refresh = capture;
    assign col_arb.refresh = capture || (state_q == st_row);      // New row, columns from 0
    assign row_arb.enable  = ((state_q == st_capture) && (|row_arb.req)) ||
                             ((state_q == st_emit) && col_arb.grp_release &&
                              !row_arb.grp_release);
    assign col_arb.enable  = (state_q == st_col) && has_credit;    // Stall frozen on no credit

    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            st_idle:    if (capture) state_nxt = st_capture;
            st_capture: state_nxt = (|row_arb.req) ? st_row : st_done;  // All rows skipped
            st_row:     state_nxt = st_col;
            st_col:     if (has_credit) state_nxt = st_emit;
            st_emit:
            begin
                if (!col_arb.grp_release)
                    state_nxt = st_col;                   // More hits in this row
                else if (row_arb.grp_release)
                    state_nxt = st_done;                  // Last row finished
                else
                    state_nxt = st_row;
            end
            st_done:    state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state_q <= st_idle;
        else
            state_q <= state_nxt;
    end

    // ----------------------------
    // Credits and event output
    // ----------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            credit_q <= cred_w'(n_credits);               // Buffer empty
        else if (evt_valid_o && !credit_i)
            credit_q <= credit_q - 1'b1;
        else if (credit_i && !evt_valid_o)
            credit_q <= credit_q + 1'b1;
    end

    assign evt_valid_o  = (state_q == st_emit);
    assign evt_row_o    = row_arb.addr;
    assign evt_col_o    = col_arb.addr;
    assign frame_done_o = (state_q == st_done);

    // Sink returns no more credits than events it took
    a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
        credit_q <= cred_w'(n_credits));

    // Column step waits for credit, so an event always has a slot
    a_no_evt_wo_credit: assert property (@(posedge clk_i) disable iff (reset_i)
        evt_valid_o |-> has_credit);

endmodule

/* pixel_readout_top.sv */
/*
 * Pixel block readout
 * Configuration registers, scan controller and the row and column
 * round-robin arbiters behind plain ports
 */

`timescale 1ns/100ps

module pixel_readout_top import readout_geom_pkg::*, readout_reg_pkg::*;
#(
    parameter int n_rows     = n_rows_dflt,
    parameter int n_cols     = n_cols_dflt,
    parameter int row_addr_w = row_addr_w_dflt,
    parameter int col_addr_w = col_addr_w_dflt,
    parameter int n_credits  = n_credits_dflt
)
(
    input  logic                     clk_i,          // System clock
    input  logic                     reset_i,        // Async reset, active high
    input  logic [n_rows*n_cols-1:0] hit_i,          // Hit vector, row major
    input  logic                     credit_i,       // Credit return from buffer
    input  logic                     cfg_we_i,       // Config write strobe
    input  logic [reg_addr_w-1:0]    cfg_addr_i,     // Config address
    input  logic [reg_data_w-1:0]    cfg_wdata_i,    // Config write data
    output logic [reg_data_w-1:0]    cfg_rdata_o,    // Config read data
    output logic                     evt_valid_o,    // Address event valid
    output logic [row_addr_w-1:0]    evt_row_o,      // Event row
    output logic [col_addr_w-1:0]    evt_col_o       // Event column
);

    logic              scan_en;                      // CTRL enable
    logic [n_rows-1:0] row_skip;                     // ROW_SKIP mask
    logic              frame_done;                   // Frame end pulse

    arb_if #(.n_lines(n_rows), .addr_w(row_addr_w)) row_bus ();
    arb_if #(.n_lines(n_cols), .addr_w(col_addr_w)) col_bus ();

    // ----------------------------
    // Registers and controller
    // ----------------------------
    readout_regs #(.n_rows(n_rows)) i_readout_regs
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .frame_done_i (frame_done),
        .scan_en_o    (scan_en),
        .row_skip_o   (row_skip)
    );

    readout_ctrl #(
        .n_rows     (n_rows),
        .n_cols     (n_cols),
        .row_addr_w (row_addr_w),
        .col_addr_w (col_addr_w),
        .n_credits  (n_credits)
    ) i_readout_ctrl
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .hit_i        (hit_i),
        .scan_en_i    (scan_en),
        .row_skip_i   (row_skip),
        .credit_i     (credit_i),
        .row_arb      (row_bus),
        .col_arb      (col_bus),
        .evt_valid_o  (evt_valid_o),
        .evt_row_o    (evt_row_o),
        .evt_col_o    (evt_col_o),
        .frame_done_o (frame_done)
    );

    // ----------------------------
    // Arbiters
    // ----------------------------
    row_arbiter #(.n_lines(n_rows), .addr_w(row_addr_w)) i_row_arbiter
    (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .arb     (row_bus)
    );

    row_arbiter #(.n_lines(n_cols), .addr_w(col_addr_w)) i_col_arbiter
    (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .arb     (col_bus)
    );

endmodule

/* tb_pixel_readout.sv */
/*
 * Pixel readout testbench
 * Drives hit frames and config writes, models the downstream buffer
 * by returning credits, and checks every address event against the
 * row-major scan order of the captured frame
 */

`timescale 1ns/100ps

module tb_pixel_readout import readout_geom_pkg::*, readout_reg_pkg::*;
();

    localparam int n_bits = n_rows_dflt * n_cols_dflt;         // Hit vector width
    localparam int evt_w  = row_addr_w_dflt + col_addr_w_dflt;  // Packed {row, col}

    typedef logic [evt_w-1:0] evt_list_t [$];

    logic                       clk_i;
    logic                       reset_i;
    logic [n_bits-1:0]          hit_i;
    logic                       credit_i;
    logic                       cfg_we_i;
    logic [reg_addr_w-1:0]      cfg_addr_i;
    logic [reg_data_w-1:0]      cfg_wdata_i;
    logic [reg_data_w-1:0]      cfg_rdata_o;
    logic                       evt_valid_o;
    logic [row_addr_w_dflt-1:0] evt_row_o;
    logic [col_addr_w_dflt-1:0] evt_col_o;

    integer                 seed;           // $random state
    evt_list_t              exp_q;          // Expected events, oldest first
    int                     pend_q [$];     // Cycle on which each credit goes back
    logic [evt_w-1:0]       exp_evt;
    logic [n_rows_dflt-1:0] skip_mask;      // Copy of ROW_SKIP
    logic [reg_data_w-1:0]  frames_prev;    // FRAMES before the last launch
    logic                   hold;           // Buffer withholds credits
    int                     cycle_cnt;
    int                     cyc_limit;      // Grows with every launched frame
    int                     err_cnt;
    int                     chk_cnt;
    int                     evt_cnt;
    int                     test_err;       // err_cnt at start of test
    int                     frames_exp;
    int                     base;

    pixel_readout_top #(
        .n_rows     (n_rows_dflt),
        .n_cols     (n_cols_dflt),
        .row_addr_w (row_addr_w_dflt),
        .col_addr_w (col_addr_w_dflt),
        .n_credits  (n_credits_dflt)
    ) i_pixel_readout_top
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .hit_i       (hit_i),
        .credit_i    (credit_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .evt_valid_o (evt_valid_o),
        .evt_row_o   (evt_row_o),
        .evt_col_o   (evt_col_o)
    );

    always #50 clk_i = ~clk_i;              // 100 ns period

    // ----------------------------
    // Reference model
    // ----------------------------
    function automatic evt_list_t scan_frame(input logic [n_bits-1:0] hits,
                                             input logic [n_rows_dflt-1:0] skip);
        evt_list_t lst;
        for (int r = 0; r < n_rows_dflt; r++)
        begin
            if (!skip[r])                   // Masked rows give nothing
            begin
                for (int c = 0; c < n_cols_dflt; c++)
                begin
                    if (hits[r*n_cols_dflt + c])
                        lst.push_back({row_addr_w_dflt'(r), col_addr_w_dflt'(c)});
                end
            end
        end
        return lst;
    endfunction

    function automatic logic [n_bits-1:0] random_frame();
        logic [n_bits-1:0] hits;
        for (int b = 0; b < n_bits; b++)
            hits[b] = (($random(seed) & 3) != 0);   // About three hits in four
        return hits;
    endfunction

    // ----------------------------
    // Event checker and buffer model
    // ----------------------------
    always @(posedge clk_i)
    begin
        if (evt_valid_o)
        begin
            evt_cnt++;
            pend_q.push_back(cycle_cnt + int'($unsigned($random(seed)) % 4));  // 0 to 3 cycles
            if (exp_q.size() == 0)
            begin
                $display("Unexpected event row %0d col %0d at time %0t",
                         evt_row_o, evt_col_o, $time);
                err_cnt++;
            end
            else
            begin
                exp_evt = exp_q.pop_front();
                chk_cnt++;
                if ({evt_row_o, evt_col_o} != exp_evt)
                begin
                    $display("[FAIL] %0t: event row %0d col %0d, expected row %0d col %0d",
                             $time, evt_row_o, evt_col_o,
                             exp_evt[evt_w-1 -: row_addr_w_dflt],
                             exp_evt[col_addr_w_dflt-1:0]);
                    err_cnt++;
                end
            end
        end
    end

    always @(negedge clk_i)
    begin
        cycle_cnt++;
        credit_i = 1'b0;
        if (!hold && pend_q.size() != 0 && pend_q[0] <= cycle_cnt)
        begin
            credit_i = 1'b1;                // One credit per cycle at most
            void'(pend_q.pop_front());
        end
    end

    always @(posedge clk_i)
    begin
        if (cycle_cnt > cyc_limit)
        begin
            $display("Timeout after %0d cycles, scan did not finish", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------
    // Stimulus tasks
    // ----------------------------
    task automatic write_reg(input logic [reg_addr_w-1:0] addr,
                             input logic [reg_data_w-1:0] data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk_i);
        cfg_we_i    = 1'b0;
        cfg_addr_i  = reg_frames_addr;      // Read port parked on FRAMES
        @(negedge clk_i);
        cyc_limit  += 2;
    endtask

    task automatic launch_frame(input logic [n_bits-1:0] hits);
        evt_list_t lst;
        lst = scan_frame(hits, skip_mask);
        foreach (lst[i])
            exp_q.push_back(lst[i]);
        frames_prev = cfg_rdata_o;
        cyc_limit  += (8 + 6 * $countones(hits)) * 4;
        hit_i       = hits;                 // Held one cycle, DUT is idle
        @(negedge clk_i);
        hit_i       = '0;
    endtask

    task automatic wait_frame();
        while (cfg_rdata_o == frames_prev)  // FRAMES moves on frame end
            @(negedge clk_i);
        frames_exp++;
        if (exp_q.size() != 0)
        begin
            $display("Frame ended with %0d expected events missing", exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
    endtask

    task automatic run_frame(input logic [n_bits-1:0] hits);
        launch_frame(hits);
        wait_frame();
    endtask

    task automatic end_test(input string name);
        $display("%s: errors %0d", name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    // ----------------------------
    // Test sequence
    // ----------------------------
    initial
    begin
        seed        = 32'h1749;
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        hit_i       = '0;
        credit_i    = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = reg_frames_addr;
        cfg_wdata_i = '0;
        hold        = 1'b0;
        skip_mask   = '0;
        cycle_cnt   = 0;
        cyc_limit   = 100;                  // Reset and idle windows
        err_cnt     = 0;
        chk_cnt     = 0;
        evt_cnt     = 0;
        test_err    = 0;
        frames_exp  = 0;
        repeat (8) @(negedge clk_i);
        reset_i     = 1'b0;

        // Enable still clear, hits must be ignored
        hit_i = random_frame();
        repeat (10) @(negedge clk_i);
        hit_i = '0;
        if (evt_cnt != 0)
        begin
            $display("Events appeared while readout was disabled");
            err_cnt++;
        end
        if (cfg_rdata_o != '0)
        begin
            $display("[FAIL] %0t: FRAMES reads %0d, expected 0", $time, cfg_rdata_o);
            err_cnt++;
        end
        end_test("reset, readout disabled");

        write_reg(reg_ctrl_addr, reg_data_w'(1 << ctrl_en_bit));

        // One hit anywhere in the array
        base = evt_cnt;
        run_frame(n_bits'(1) << ($unsigned($random(seed)) % n_bits));
        if (evt_cnt - base != 1)
        begin
            $display("[FAIL] %0t: %0d events for a single hit", $time, evt_cnt - base);
            err_cnt++;
        end
        if (cfg_rdata_o != reg_data_w'(frames_exp))
        begin
            $display("[FAIL] %0t: FRAMES reads %0d, expected %0d",
                     $time, cfg_rdata_o, frames_exp);
            err_cnt++;
        end
        end_test("single hit");

        repeat (6) run_frame(random_frame());
        end_test("random dense frames");

        // Rows 0, 2, 5 and 7 masked, last frame has hits in row 0 only
        skip_mask = n_rows_dflt'('hA5);
        write_reg(reg_row_skip_addr, reg_data_w'(skip_mask));
        repeat (3) run_frame(random_frame());
        run_frame(64'h0000_0000_0000_00FF);
        skip_mask = '0;
        write_reg(reg_row_skip_addr, reg_data_w'(skip_mask));
        end_test("row skip");

        // Buffer full, only the initial credits may be spent
        while (pend_q.size() != 0)
            @(posedge clk_i);
        hold = 1'b1;
        @(negedge clk_i);
        base = evt_cnt;
        launch_frame(64'h0000_00FF_0000_0F0F);
        cyc_limit += 40;
        repeat (40) @(negedge clk_i);
        if (evt_cnt - base > n_credits_dflt)
        begin
            $display("[FAIL] %0t: %0d events with credits withheld, limit %0d",
                     $time, evt_cnt - base, n_credits_dflt);
            err_cnt++;
        end
        if (cfg_rdata_o != frames_prev)
        begin
            $display("Frame finished while credits were withheld");
            err_cnt++;
        end
        @(posedge clk_i);
        hold = 1'b0;                        // Buffer drains, scan resumes
        wait_frame();
        end_test("credit back-pressure");

        repeat (3) run_frame(random_frame());
        if (cfg_rdata_o != reg_data_w'(frames_exp))
        begin
            $display("[FAIL] %0t: FRAMES reads %0d, expected %0d",
                     $time, cfg_rdata_o, frames_exp);
            err_cnt++;
        end
        end_test("frame count");

        $display("checks %0d, events %0d, frames %0d, errors %0d",
                 chk_cnt, evt_cnt, frames_exp, err_cnt);
        if (err_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* pixel_readout.f */
readout_geom_pkg.sv
readout_reg_pkg.sv
arb_if.sv
priority_arb.sv
row_arbiter.sv
readout_regs.sv
readout_ctrl.sv
pixel_readout_top.sv
tb_pixel_readout.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pixel readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_pixel_readout \
    -f pixel_readout.f \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_pixel_readout)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
    exit 0
else
    exit 1
fi
